//--- verification/bif_dpath_vectors.txt
# ctl lbd_in cd_in lbd_out cd_out oe, all hex, one clock step per line
# ctl bits dstb_n ecreq emd_n wlbd_n, oe bits lbd_oe cd_oe
D 1234 abcd 0000 0000 1
C 1234 abcd 0000 0000 2
5 1111 0000 0000 1111 1
5 2222 0000 0000 2222 1
D 5aa5 0000 0000 0000 1
D ffff 0000 0000 5aa5 1
D 0f0f 0000 0000 5aa5 1
5 a55a 0000 0000 a55a 1
D c33c 0000 0000 5aa5 1
D 0000 0000 0000 c33c 1
8 0000 1357 0000 0000 2
C 0000 8001 0000 0000 2
C 0000 ffff 8001 0000 2
C 0000 1234 8001 0000 2
8 0000 00ff 8001 0000 2
C 0000 ff00 8001 0000 2
C 0000 0000 ff00 0000 2
F aaaa 5555 0000 0000 0
E aaaa 5555 0000 0000 0
A 0000 7777 0000 0000 0
E 0000 4321 0000 0000 0
E 0000 0000 0000 0000 0
C 0000 9999 4321 0000 2
D 1111 0000 0000 c33c 1
7 beef 0000 0000 0000 0
F cafe 0000 0000 0000 0
D 0000 0000 0000 cafe 1
C 0000 0000 4321 0000 2
5 00ff 0000 0000 00ff 1
5 ff00 0000 0000 ff00 1
D 0001 0000 0000 cafe 1
D 8000 0000 0000 0001 1
8 0000 a5a5 4321 0000 2
C 0000 0180 4321 0000 2
C 0000 ffff 0180 0000 2
4 3c3c 0000 0180 0000 2
5 3c3c 0000 0000 3c3c 1
D 7e7e 0000 0000 0001 1

//--- filelist.f
hdl/bif_pkg.sv
hdl/bif_dpath_decode.sv
hdl/ttl_74646.sv
hdl/bif_dpath_cdlbd.sv
hdl/bif_dpath_top.sv
verification/bif_dpath_props.sv
verification/bif_dpath_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and fails if the log reports failure
set -e

cd "$(dirname "$0")"

LOG=sim.log
SIM=obj_dir/sim_bif_dpath

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module bif_dpath_tb \
  -o sim_bif_dpath

./"$SIM" > "$LOG" 2>&1 || { cat "$LOG"; echo "Simulation exited with an error"; exit 1; }

cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
  exit 1
fi

exit 0

//--- verification/bif_dpath_tb.sv
// Testbench for the CPU data to local bus data path, replays the vectors file then checks a random phase
`timescale 1ns/1ps

module bif_dpath_tb;

  import bif_pkg::*;

  localparam int    half_period  = 50;                      // 100 ns clock
  localparam int    reset_cycles = 4;
  localparam int    rand_steps   = 200;
  localparam int    margin       = 50;                      // Spare cycles before the watchdog fires
  localparam        seed         = 32'h0a3f_bd50;
  localparam string vec_file     = "verification/bif_dpath_vectors.txt";

  // One step of stimulus with its expected response
  typedef struct packed {
    bif_ctl_t   ctl;
    word_t      lbd_in;
    word_t      cd_in;
    word_t      exp_lbd;    // Expected lbd_out
    word_t      exp_cd;     // Expected cd_out
    logic [1:0] exp_oe;     // Expected {lbd_oe, cd_oe}
  } step_t;

  // DUT ports
  logic     clk;
  logic     arst_n;
  bif_ctl_t ctl;
  word_t    lbd_in;
  word_t    cd_in;
  word_t    lbd_out;
  word_t    cd_out;
  logic     lbd_oe;
  logic     cd_oe;

  // Run bookkeeping
  step_t       vectors[$];   // Directed steps from the file
  int          err_cnt;
  int          step_no;
  int          cycle_cnt   = 0;
  int          cycle_limit = 1000;   // Replaced once the vectors are loaded
  logic [31:0] rng;

  // Reference model state
  word_t mdl_a;          // Stored local bus word, A registers
  word_t mdl_b;          // Stored CPU bus word, B registers
  logic  mdl_dstb_q;     // dstb_n seen at the last rising edge
  logic  mdl_ecreq_q;    // ecreq seen at the last rising edge

  bif_dpath_top i_dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .ctl     (ctl),
    .lbd_in  (lbd_in),
    .cd_in   (cd_in),
    .lbd_out (lbd_out),
    .cd_out  (cd_out),
    .lbd_oe  (lbd_oe),
    .cd_oe   (cd_oe)
  );

  always #half_period clk = ~clk;

  // Watchdog, ends a run that never reaches its closing line
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout, the run did not finish within %0d clock cycles", cycle_limit);
      $display("Errors counted before the timeout: %0d", err_cnt);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // 32 bit xorshift, shifts 13, 17, 5
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s at step %0d: expected %h, got %h", name, step_no, exp, act);
      err_cnt++;
    end
  endtask

  // Expected outputs from the bus rules and the model's stored words
  function automatic step_t add_expect(input step_t s);
    logic oe_on;
    oe_on = ~s.ctl.emd_n;
    s.exp_oe  = {oe_on & ~s.ctl.wlbd_n, oe_on & s.ctl.wlbd_n};
    s.exp_lbd = '0;                                          // Released bus reads zero
    s.exp_cd  = '0;
    if (s.exp_oe[0]) s.exp_cd = s.ctl.dstb_n ? mdl_a : s.lbd_in;   // Stored or live write
    if (s.exp_oe[1]) s.exp_lbd = mdl_b;                             // Read is always stored
    return s;
  endfunction

  // Model update for the coming rising edge, strobe high now and low before
  task automatic model_clock(input step_t s);
    if (s.ctl.dstb_n && !mdl_dstb_q) mdl_a = s.lbd_in;
    if (s.ctl.ecreq && !mdl_ecreq_q) mdl_b = s.cd_in;
    mdl_dstb_q  = s.ctl.dstb_n;
    mdl_ecreq_q = s.ctl.ecreq;
  endtask

  // Called on a falling edge, returns on the next one
  task automatic run_step(input step_t s);
    ctl    = s.ctl;
    lbd_in = s.lbd_in;
    cd_in  = s.cd_in;
    #(half_period - 10);                                     // Sample 10 ns ahead of the rise
    check_value("lbd_out", s.exp_lbd, lbd_out);
    check_value("cd_out", s.exp_cd, cd_out);
    check_value("lbd_oe", 16'(s.exp_oe[1]), 16'(lbd_oe));
    check_value("cd_oe", 16'(s.exp_oe[0]), 16'(cd_oe));
    model_clock(s);
    @(negedge clk);
    step_no++;
  endtask

  // Columns ctl lbd_in cd_in lbd_out cd_out oe, lines with # are notes
  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    step_t       s;
    logic [3:0]  c;
    logic [15:0] lbd;
    logic [15:0] cd;
    logic [15:0] el;
    logic [15:0] ec;
    logic [1:0]  eo;
    fd = $fopen(vec_file, "r");
    if (fd == 0) begin
      $display("Could not open the vectors file %s, directed phase skipped", vec_file);
      err_cnt++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0) break;
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;   // Blank line or note
      n = $sscanf(line, "%h %h %h %h %h %h", c, lbd, cd, el, ec, eo);
      if (n != 6) begin
        $display("Vectors file line could not be read: %s", line);
        err_cnt++;
      end else begin
        s.ctl     = bif_ctl_t'(c);
        s.lbd_in  = lbd;
        s.cd_in   = cd;
        s.exp_lbd = el;
        s.exp_cd  = ec;
        s.exp_oe  = eo;
        vectors.push_back(s);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    step_t s;
    int    n_vec;
    clk         = 1'b0;
    arst_n      = 1'b0;
    ctl         = 4'b1101;      // Strobes high, enabled, write direction
    lbd_in      = '0;
    cd_in       = '0;
    err_cnt     = 0;
    step_no     = 0;
    rng         = seed;
    mdl_a       = '0;
    mdl_b       = '0;
    mdl_dstb_q  = 1'b1;         // Reset leaves both previous levels high
    mdl_ecreq_q = 1'b1;

    load_vectors();
    cycle_limit = vectors.size() + rand_steps + reset_cycles + margin;

    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Strobes stay high out of reset, so this edge must load nothing
    // The first directed line then reads the A registers back as zero
    s.ctl    = 4'b1101;
    s.lbd_in = 16'h1234;
    s.cd_in  = 16'habcd;
    s = add_expect(s);
    run_step(s);

    // Directed phase, model follows along to stay in step with the DUT
    foreach (vectors[i]) run_step(vectors[i]);
    n_vec = step_no;

    // Random phase checked against the model
    repeat (rand_steps) begin
      rng = xorshift32(rng);
      s.ctl       = bif_ctl_t'(rng[3:0]);
      s.ctl.emd_n = (rng[6:4] == 3'd0);     // Enabled most of the time
      s.lbd_in    = rng[31:16];
      rng = xorshift32(rng);
      s.cd_in     = rng[15:0];
      s = add_expect(s);
      run_step(s);
    end

    $display("Run done, %0d directed steps, %0d random steps, %0d errors",
             n_vec, step_no - n_vec, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verification/bif_dpath_props.sv
// Concurrent assertions on output gating and register capture, bound into the datapath top level
`timescale 1ns/1ps

module bif_dpath_props (
  input logic              clk,
  input logic              arst_n,
  input bif_pkg::bif_ctl_t ctl,       // Raw bus levels
  input bif_pkg::xfer_t    xfer,      // Decoded control inside the top level
  input bif_pkg::word_t    lbd_in,
  input bif_pkg::word_t    cd_in,
  input bif_pkg::word_t    lbd_out,
  input bif_pkg::word_t    cd_out,
  input logic              lbd_oe,
  input logic              cd_oe
);

  // Disabled block releases both buses
  a_disabled_zero: assert property (@(posedge clk) disable iff (!arst_n)
    ctl.emd_n |-> (lbd_out == '0 && cd_out == '0 && !lbd_oe && !cd_oe))
    else $error("Output or enable flag active while emd_n is high");

  // Only one bus driven at a time
  a_one_side: assert property (@(posedge clk) disable iff (!arst_n)
    !(lbd_oe && cd_oe))
    else $error("lbd_oe and cd_oe both high");

  // Stored write word is the local bus word at the capture edge
  a_cap_ab: assert property (@(posedge clk) disable iff (!arst_n)
    xfer.cap_ab |=> (!(cd_oe && ctl.dstb_n) || cd_out == $past(lbd_in)))
    else $error("cd_out differs from the word captured by dstb_n");

  // Stored read word is the CPU bus word at the capture edge
  a_cap_ba: assert property (@(posedge clk) disable iff (!arst_n)
    xfer.cap_ba |=> (!lbd_oe || lbd_out == $past(cd_in)))
    else $error("lbd_out differs from the word captured by ecreq");

endmodule

bind bif_dpath_top bif_dpath_props i_props (
  .clk     (clk),
  .arst_n  (arst_n),
  .ctl     (ctl),
  .xfer    (xfer),
  .lbd_in  (lbd_in),
  .cd_in   (cd_in),
  .lbd_out (lbd_out),
  .cd_out  (cd_out),
  .lbd_oe  (lbd_oe),
  .cd_oe   (cd_oe)
);

//--- hdl/bif_dpath_top.sv
// Top level of the CPU data to local bus data path, decode stage feeding the transceiver datapath
`timescale 1ns/1ps

module bif_dpath_top (
  input  logic              clk,       // System clock
  input  logic              arst_n,    // Asynchronous reset, active low
  input  bif_pkg::bif_ctl_t ctl,       // Raw bus strobes and levels
  input  bif_pkg::word_t    lbd_in,    // Local bus data in
  input  bif_pkg::word_t    cd_in,     // CPU data in
  output bif_pkg::word_t    lbd_out,   // Local bus data out
  output bif_pkg::word_t    cd_out,    // CPU data out
  output logic              lbd_oe,    // Local bus drive enable
  output logic              cd_oe      // CPU bus drive enable
);

  import bif_pkg::*;

  // Decoded control between the stages
  xfer_t xfer;

  // Strobe sampling and level decode
  bif_dpath_decode i_decode (
    .clk    (clk),
    .arst_n (arst_n),
    .ctl    (ctl),
    .xfer   (xfer)
  );

  // Byte lanes and output gating
  // Registered paths see the capture one edge after the strobe rise is sampled,
  // live paths are combinational from the inputs
  bif_dpath_cdlbd i_cdlbd (
    .clk     (clk),
    .arst_n  (arst_n),
    .xfer    (xfer),
    .lbd_in  (lbd_in),
    .cd_in   (cd_in),
    .lbd_out (lbd_out),
    .cd_out  (cd_out),
    .lbd_oe  (lbd_oe),
    .cd_oe   (cd_oe)
  );

endmodule

//--- hdl/bif_dpath_cdlbd.sv
// CPU data to local bus data datapath, two 74646 byte lanes between LBD and CD with output gating
`timescale 1ns/1ps

module bif_dpath_cdlbd (
  input  logic           clk,       // System clock
  input  logic           arst_n,    // Asynchronous reset, active low
  input  bif_pkg::xfer_t xfer,      // Decoded transfer control
  input  bif_pkg::word_t lbd_in,    // Local bus data in, A side
  input  bif_pkg::word_t cd_in,     // CPU data in, B side
  output bif_pkg::word_t lbd_out,   // Local bus data out
  output bif_pkg::word_t cd_out,    // CPU data out
  output logic           lbd_oe,    // Datapath drives the local bus
  output logic           cd_oe      // Datapath drives the CPU bus
);

  import bif_pkg::*;

  // Words as joined from the lane outputs
  word_t lbd_lane;   // A side outputs of all lanes
  word_t cd_lane;    // B side outputs of all lanes

  // One transceiver per byte, lane 1 is bits 15..8
  // All lanes share the same strobes, as CHIP_7B and CHIP_6B do on the sheet
  for (genvar i = 0; i < lanes; i++) begin : g_lane
    ttl_74646 i_lane (
      .clk    (clk),
      .arst_n (arst_n),
      .cap_ab (xfer.cap_ab),                       // Data strobe rising
      .cap_ba (xfer.cap_ba),                       // CPU request rising
      .dir_ab (xfer.dir_ab),                       // From wlbd_n
      .sel_ab (xfer.sel_ab),                       // From dstb_n
      .oe     (xfer.oe),
      .a_in   (lbd_in[i*lane_w +: lane_w]),
      .b_in   (cd_in[i*lane_w +: lane_w]),
      .a_out  (lbd_lane[i*lane_w +: lane_w]),
      .b_out  (cd_lane[i*lane_w +: lane_w])
    );
  end

  // Which bus this block drives, used as the board tri-state enables
  // Never both, dir_ab picks one side
  assign cd_oe  = xfer.oe &  xfer.dir_ab;   // Write, LBD toward CD
  assign lbd_oe = xfer.oe & ~xfer.dir_ab;   // Read, stored CD toward LBD

  // Board level gating, a released bus reads as zero
  // CD is pulled to zero while emd_n is high
  assign cd_out  = cd_oe  ? cd_lane  : '0;
  assign lbd_out = lbd_oe ? lbd_lane : '0;

  // Summary of the paths
  // wlbd_n high, dstb_n low    cd_out follows lbd_in
  // wlbd_n high, dstb_n high   cd_out holds lbd_in from the dstb_n rise
  // wlbd_n low                 lbd_out holds cd_in from the last ecreq rise
  // emd_n high                 both zero, registers unchanged

endmodule

//--- hdl/ttl_74646.sv
// Byte wide registered bus transceiver in the manner of a 74646, one instance per datapath lane
`timescale 1ns/1ps

module ttl_74646 (
  input  logic           clk,      // System clock, replaces the CLKAB and CLKBA pins
  input  logic           arst_n,   // Asynchronous reset, active low
  input  logic           cap_ab,   // Load A register, CLKAB rising
  input  logic           cap_ba,   // Load B register, CLKBA rising
  input  logic           dir_ab,   // DIR, high drives the B side
  input  logic           sel_ab,   // SAB, high shows stored A on the B side
  input  logic           oe,       // Inverse of OE_n
  input  bif_pkg::byte_t a_in,     // A side data in
  input  bif_pkg::byte_t b_in,     // B side data in
  output bif_pkg::byte_t a_out,    // A side data out, zero when not driven
  output bif_pkg::byte_t b_out     // B side data out, zero when not driven
);

  import bif_pkg::*;

  // Storage registers
  byte_t a_q;        // Last captured A input
  byte_t b_q;        // Last captured B input

  // Selected data for each direction before gating
  byte_t ab_data;    // Toward the B side
  byte_t ba_data;    // Toward the A side

  // Output enables per side
  logic drive_b;
  logic drive_a;

  // A register, loads on the capture pulse only
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      a_q <= '0;
    end else if (cap_ab) begin
      a_q <= a_in;
    end
  end

  // B register, independent of the A side
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      b_q <= '0;
    end else if (cap_ba) begin
      b_q <= b_in;
    end
  end

  // Live or stored selection
  // On the board SBA is strapped high, so B to A is always stored
  always_comb begin
    ab_data = sel_ab ? a_q : a_in;   // Stored or real time A
    ba_data = b_q;                   // Stored B only
  end

  // Only one side drives at a time, chosen by DIR
  assign drive_b = oe &  dir_ab;
  assign drive_a = oe & ~dir_ab;

  // A side that is off reads as zero, standing in for a floating bus
  assign b_out = drive_b ? ab_data : '0;
  assign a_out = drive_a ? ba_data : '0;

  // Truth table, oe high
  // dir_ab  sel_ab  b_out    a_out
  //   1       0     a_in     0
  //   1       1     a_q      0
  //   0       x     0        b_q
  // With oe low both outputs are zero and the registers still load

endmodule

//--- hdl/bif_dpath_decode.sv
// Decode stage that samples the bus strobes on clk and builds the transfer control for the datapath
`timescale 1ns/1ps

module bif_dpath_decode (
  input  logic              clk,      // System clock, strobes sampled on the rising edge
  input  logic              arst_n,   // Asynchronous reset, active low
  input  bif_pkg::bif_ctl_t ctl,      // Raw strobe and level inputs
  output bif_pkg::xfer_t    xfer      // Capture pulses and decoded levels
);

  // Previous strobe levels, one flop per strobe
  logic dstb_n_q;   // dstb_n at the last rising edge
  logic ecreq_q;    // ecreq at the last rising edge

  // Rising edge detect terms
  logic dstb_rise;
  logic ecreq_rise;

  // Both flops come out of reset high
  // A strobe that is already high after reset then gives no pulse
  // It has to drop low and come back before anything is captured
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dstb_n_q <= 1'b1;
      ecreq_q  <= 1'b1;
    end else begin
      dstb_n_q <= ctl.dstb_n;
      ecreq_q  <= ctl.ecreq;
    end
  end

  // High now, low at the previous edge
  // The register loads at the edge where this is seen
  assign dstb_rise  = ctl.dstb_n & ~dstb_n_q;
  assign ecreq_rise = ctl.ecreq  & ~ecreq_q;

  // Map onto the active high transfer struct
  always_comb begin
    xfer.cap_ab = dstb_rise;          // LBD into the A registers
    xfer.cap_ba = ecreq_rise;         // CD into the B registers

    // Level fields pass straight through, no added latency
    xfer.dir_ab = ctl.wlbd_n;         // High means local bus to CPU bus
    xfer.sel_ab = ctl.dstb_n;         // Strobe high shows the stored A value
    xfer.oe     = ~ctl.emd_n;         // Enable is active low on the bus
  end

  // Note on sel_ab
  // While dstb_n is low the A to B path is live
  // The same edge that raises sel_ab also loads the A register,
  // so the CPU bus sees the captured word from that edge on

endmodule

//--- hdl/bif_pkg.sv
// Shared types and lane constants for the CPU data to local bus data path, imported by every block
package bif_pkg;

  // Lane geometry, two 74646 style byte lanes per bus word
  localparam int lane_w = 8;                  // Bits per transceiver lane
  localparam int lanes  = 2;                  // Lane 1 upper byte, lane 0 lower byte
  localparam int word_w = lane_w * lanes;     // Full CPU and local bus width

  // One byte lane as seen on either side of a transceiver
  typedef logic [lane_w-1:0] byte_t;

  // One bus word, CD15-0 or LBD15-0
  typedef logic [word_w-1:0] word_t;

  // Raw bus control levels as they arrive from the rest of the CPU
  // Field order gives the ctl nibble, dstb_n in bit 3 down to wlbd_n in bit 0
  typedef struct packed {
    logic dstb_n;   // Data strobe, active low, loads the A register on its rise
    logic ecreq;    // CPU request strobe, loads the B register on its rise
    logic emd_n;    // Output enable, active low
    logic wlbd_n;   // Direction, high drives the CPU bus from the local bus
  } bif_ctl_t;

  // Decoded transfer control, all active high
  // The capture pulses are one clock wide and sampled at the rising edge
  typedef struct packed {
    logic cap_ab;   // Load A register from the local bus side
    logic cap_ba;   // Load B register from the CPU bus side
    logic dir_ab;   // A to B, local bus drives CPU bus
    logic sel_ab;   // A to B path shows the stored A value
    logic oe;       // Either output may drive
  } xfer_t;

  // Sizes that the decode and the datapath rely on
  // bif_ctl_t  4 bits
  // xfer_t     5 bits
  // word_t     lanes times lane_w bits

  // Typical sequences on the bus
  // Write  wlbd_n high, dstb_n low passes LBD straight to CD
  //        dstb_n rising stores LBD, CD then holds it while dstb_n stays high
  // Read   wlbd_n low, ecreq rising stores CD, LBD then shows it
  // Idle   emd_n high, both buses read zero, stored bytes kept

endpackage
